//--- include/backend_settings.svh
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// Integer data path width
`define BE_XLEN 64

// Architectural register file
`define BE_NUM_REGS 32
`define BE_REG_IDX_W 5

// Data-memory port, byte address
`define BE_ADDR_W 32

// One strobe bit per byte of a doubleword
`define BE_STRB_W 8

`endif

//--- source/backend_pkg.sv
`default_nettype none

`include "backend_settings.svh"

package backend_pkg;

    // RV64 major opcodes handled by the back end
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        IDLE,
        ISSUE,
        EXECUTE,
        MEM_ACCESS,
        MEM_WAIT,
        WRITEBACK
    } backend_state_e;

    // Immediate arrives already sign-extended from the decoder
    typedef struct packed {
        logic [`BE_XLEN-1:0]      pc;
        opcode_e                  opcode;
        logic [`BE_REG_IDX_W-1:0] rd;
        logic [`BE_REG_IDX_W-1:0] rs1;
        logic [`BE_REG_IDX_W-1:0] rs2;
        logic [2:0]               funct3;
        logic [6:0]               funct7;
        logic [`BE_XLEN-1:0]      imm;
    } decoded_instr_t;

    typedef struct packed {
        logic [`BE_XLEN-1:0]      result;
        logic [`BE_REG_IDX_W-1:0] rd;
        logic                     reg_we;
        logic                     mem_re;
        logic                     mem_we;
        logic [2:0]               mem_size;
        logic [`BE_XLEN-1:0]      mem_addr;
        logic [`BE_XLEN-1:0]      store_data;
        logic                     branch_taken;
        logic [`BE_XLEN-1:0]      branch_target;
    } exec_result_t;

    typedef struct packed {
        logic                stall;
        logic                redirect;
        logic [`BE_XLEN-1:0] redirect_pc;
    } backend_ctrl_t;

    typedef struct packed {
        logic [`BE_ADDR_W-1:0] addr;
        logic [`BE_XLEN-1:0]   wdata;
        logic [`BE_STRB_W-1:0] wstrb;
        logic                  we;
    } dmem_req_t;

    typedef struct packed {
        logic [`BE_XLEN-1:0] data;
        logic                error;
    } dmem_resp_t;

endpackage

`default_nettype wire

//--- source/backend_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module backend_fsm import backend_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           frontend_valid,
    input  exec_result_t   exec_result,
    input  logic           dmem_ready,
    input  logic           dmem_resp_valid,
    input  logic           dmem_resp_error,
    output backend_state_e state,
    output logic           issue_en,
    output logic           exec_en,
    output logic           mem_req_active,
    output logic           wb_en,
    output backend_ctrl_t  backend_ctrl,
    output logic           instr_retired,
    output logic           mem_fault
);

    backend_state_e next_state;
    logic           is_mem;

    // Memory flags are valid from the ISSUE cycle on
    assign is_mem = exec_result.mem_re || exec_result.mem_we;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (frontend_valid) begin
                    next_state = ISSUE;
                end
            end
            ISSUE: next_state = EXECUTE;
            EXECUTE: next_state = is_mem ? MEM_ACCESS : WRITEBACK;
            MEM_ACCESS: begin
                if (dmem_ready) begin
                    next_state = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (dmem_resp_valid) begin
                    next_state = dmem_resp_error ? IDLE : WRITEBACK;
                end
            end
            WRITEBACK: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign issue_en       = (state == IDLE) && frontend_valid;
    assign exec_en        = (state == EXECUTE);
    assign mem_req_active = (state == MEM_ACCESS);

    // x0 writes are filtered here
    assign wb_en = (state == WRITEBACK) && exec_result.reg_we && (exec_result.rd != '0);

    assign instr_retired = (state == WRITEBACK);
    assign mem_fault     = (state == MEM_WAIT) && dmem_resp_valid && dmem_resp_error;

    always_comb begin
        backend_ctrl.stall       = (state != IDLE);
        backend_ctrl.redirect    = (state == WRITEBACK) && exec_result.branch_taken;
        backend_ctrl.redirect_pc = backend_ctrl.redirect ? exec_result.branch_target : '0;
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module register_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`BE_REG_IDX_W-1:0] rs1_idx,
    input  logic [`BE_REG_IDX_W-1:0] rs2_idx,
    input  logic [`BE_REG_IDX_W-1:0] wr_idx,
    input  logic                     wr_en,
    input  logic [`BE_XLEN-1:0]      wr_data,
    output logic [`BE_XLEN-1:0]      rs1_data,
    output logic [`BE_XLEN-1:0]      rs2_data
);

    logic [`BE_XLEN-1:0] regs [0:`BE_NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 is hardwired to zero
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module execute_unit import backend_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_en,
    input  logic                exec_en,
    input  decoded_instr_t      frontend_instr,
    input  logic [`BE_XLEN-1:0] rs1_data,
    input  logic [`BE_XLEN-1:0] rs2_data,
    output decoded_instr_t      instr,
    output exec_result_t        exec_result
);

    logic [`BE_XLEN-1:0] op_a;
    logic [`BE_XLEN-1:0] op_b;
    logic                operand_load;
    exec_result_t        res_d;

    // Shared by OP and OP-IMM
    function automatic logic [`BE_XLEN-1:0] alu_op(
        input logic [2:0]          f3,
        input logic                sub,
        input logic                arith,
        input logic [`BE_XLEN-1:0] a,
        input logic [`BE_XLEN-1:0] b
    );
        logic [`BE_XLEN-1:0] r;
        r = '0;
        case (f3)
            3'b000: r = sub ? a - b : a + b;
            3'b001: r = a << b[5:0];
            3'b010: r = {63'b0, $signed(a) < $signed(b)};
            3'b011: r = {63'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: r = arith ? $unsigned($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'b110: r = a | b;
            3'b111: r = a & b;
            default: r = '0;
        endcase
        return r;
    endfunction

    always_comb begin
        res_d               = '0;
        res_d.rd            = instr.rd;
        res_d.mem_size      = instr.funct3;
        res_d.mem_addr      = op_a + instr.imm;
        res_d.store_data    = op_b;
        res_d.branch_target = instr.pc + instr.imm;
        case (instr.opcode)
            LUI: begin
                res_d.result = instr.imm;
                res_d.reg_we = 1'b1;
            end
            AUIPC: begin
                res_d.result = instr.pc + instr.imm;
                res_d.reg_we = 1'b1;
            end
            OP_IMM: begin
                // funct7 only selects SRAI here, ADDI has no subtract form
                res_d.result = alu_op(instr.funct3, 1'b0, instr.funct7[5], op_a, instr.imm);
                res_d.reg_we = 1'b1;
            end
            OP: begin
                res_d.result = alu_op(instr.funct3, instr.funct7[5], instr.funct7[5],
                                      op_a, op_b);
                res_d.reg_we = 1'b1;
            end
            BRANCH: begin
                case (instr.funct3)
                    3'b000: res_d.branch_taken = (op_a == op_b);
                    3'b001: res_d.branch_taken = (op_a != op_b);
                    3'b100: res_d.branch_taken = ($signed(op_a) < $signed(op_b));
                    3'b101: res_d.branch_taken = ($signed(op_a) >= $signed(op_b));
                    3'b110: res_d.branch_taken = (op_a < op_b);
                    3'b111: res_d.branch_taken = (op_a >= op_b);
                    default: res_d.branch_taken = 1'b0;
                endcase
            end
            JAL: begin
                res_d.result       = instr.pc + 64'd4;
                res_d.reg_we       = 1'b1;
                res_d.branch_taken = 1'b1;
            end
            JALR: begin
                res_d.result        = instr.pc + 64'd4;
                res_d.reg_we        = 1'b1;
                res_d.branch_taken  = 1'b1;
                res_d.branch_target = (op_a + instr.imm) & ~64'h1;
            end
            LOAD: begin
                res_d.reg_we = 1'b1;
                res_d.mem_re = 1'b1;
            end
            STORE: res_d.mem_we = 1'b1;
            default: res_d.reg_we = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr        <= '0;
            op_a         <= '0;
            op_b         <= '0;
            operand_load <= 1'b0;
            exec_result  <= '0;
        end else begin
            operand_load <= issue_en;
            if (issue_en) begin
                instr <= frontend_instr;
                // Early memory flags let the FSM leave EXECUTE on time
                exec_result.mem_re <= (frontend_instr.opcode == LOAD);
                exec_result.mem_we <= (frontend_instr.opcode == STORE);
            end
            // Register file is read in ISSUE from the latched indices
            if (operand_load) begin
                op_a <= rs1_data;
                op_b <= rs2_data;
            end
            if (exec_en) begin
                exec_result <= res_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module load_store_unit import backend_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_req_active,
    input  exec_result_t        exec_result,
    input  logic                dmem_resp_valid,
    input  dmem_resp_t          dmem_resp,
    output logic                dmem_req_valid,
    output dmem_req_t           dmem_req,
    output logic [`BE_XLEN-1:0] wb_data
);

    logic [2:0]          byte_off;
    logic [`BE_XLEN-1:0] resp_shifted;
    logic [`BE_XLEN-1:0] load_aligned;
    logic [`BE_XLEN-1:0] load_q;

    assign byte_off       = exec_result.mem_addr[2:0];
    assign dmem_req_valid = mem_req_active;

    always_comb begin
        dmem_req.addr  = {exec_result.mem_addr[`BE_ADDR_W-1:3], 3'b000};
        dmem_req.we    = exec_result.mem_we;
        dmem_req.wdata = exec_result.store_data << {byte_off, 3'b000};
        case (exec_result.mem_size[1:0])
            2'b00: dmem_req.wstrb = 8'h01 << byte_off;
            2'b01: dmem_req.wstrb = 8'h03 << byte_off;
            2'b10: dmem_req.wstrb = 8'h0f << byte_off;
            default: dmem_req.wstrb = 8'hff;
        endcase
    end

    // Bring the addressed bytes down to bit 0
    assign resp_shifted = dmem_resp.data >> {byte_off, 3'b000};

    always_comb begin
        case (exec_result.mem_size)
            3'b000: load_aligned = {{56{resp_shifted[7]}}, resp_shifted[7:0]};
            3'b001: load_aligned = {{48{resp_shifted[15]}}, resp_shifted[15:0]};
            3'b010: load_aligned = {{32{resp_shifted[31]}}, resp_shifted[31:0]};
            3'b100: load_aligned = {56'b0, resp_shifted[7:0]};
            3'b101: load_aligned = {48'b0, resp_shifted[15:0]};
            3'b110: load_aligned = {32'b0, resp_shifted[31:0]};
            default: load_aligned = resp_shifted;
        endcase
    end

    // Response data is only valid for one cycle, WRITEBACK comes after it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= '0;
        end else if (dmem_resp_valid && !dmem_resp.error) begin
            load_q <= load_aligned;
        end
    end

    assign wb_data = exec_result.mem_re ? load_q : exec_result.result;

endmodule

`default_nettype wire

//--- source/backend_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module backend_top import backend_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           frontend_valid,
    input  decoded_instr_t frontend_instr,
    output backend_ctrl_t  backend_ctrl,
    output logic           dmem_req_valid,
    output dmem_req_t      dmem_req,
    input  logic           dmem_ready,
    input  logic           dmem_resp_valid,
    input  dmem_resp_t     dmem_resp,
    output logic           instr_retired,
    output logic           mem_fault
);

    backend_state_e      state;
    logic                issue_en;
    logic                exec_en;
    logic                mem_req_active;
    logic                wb_en;
    exec_result_t        exec_result;
    decoded_instr_t      instr;
    logic [`BE_XLEN-1:0] rs1_data;
    logic [`BE_XLEN-1:0] rs2_data;
    logic [`BE_XLEN-1:0] wb_data;

    backend_fsm u_fsm (
        .clk             (clk),
        .rst_n           (rst_n),
        .frontend_valid  (frontend_valid),
        .exec_result     (exec_result),
        .dmem_ready      (dmem_ready),
        .dmem_resp_valid (dmem_resp_valid),
        .dmem_resp_error (dmem_resp.error),
        .state           (state),
        .issue_en        (issue_en),
        .exec_en         (exec_en),
        .mem_req_active  (mem_req_active),
        .wb_en           (wb_en),
        .backend_ctrl    (backend_ctrl),
        .instr_retired   (instr_retired),
        .mem_fault       (mem_fault)
    );

    // Operands come from the latched instruction
    register_file u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (instr.rs1),
        .rs2_idx  (instr.rs2),
        .wr_idx   (exec_result.rd),
        .wr_en    (wb_en),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_unit u_exec (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_en       (issue_en),
        .exec_en        (exec_en),
        .frontend_instr (frontend_instr),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .instr          (instr),
        .exec_result    (exec_result)
    );

    load_store_unit u_lsu (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_req_active  (mem_req_active),
        .exec_result     (exec_result),
        .dmem_resp_valid (dmem_resp_valid),
        .dmem_resp       (dmem_resp),
        .dmem_req_valid  (dmem_req_valid),
        .dmem_req        (dmem_req),
        .wb_data         (wb_data)
    );

endmodule

`default_nettype wire

//--- bench/backend_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module backend_assertions import backend_pkg::*; (
    input logic           clk,
    input logic           rst_n,
    input backend_state_e state,
    input backend_ctrl_t  backend_ctrl,
    input logic           dmem_req_valid,
    input dmem_req_t      dmem_req,
    input logic           dmem_ready,
    input logic           instr_retired,
    input logic           mem_fault
);

    // Read by the testbench at the end of the run
    int failures = 0;

    // Request held until the memory takes it
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_valid && !dmem_ready |=> dmem_req_valid && $stable(dmem_req))
        else begin
            $error("dmem_req changed before dmem_ready");
            failures++;
        end

    stall_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (state != IDLE) |-> backend_ctrl.stall)
        else begin
            $error("stall low outside IDLE");
            failures++;
        end

    retire_xor_fault: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_retired && mem_fault))
        else begin
            $error("instr_retired and mem_fault high together");
            failures++;
        end

endmodule

bind backend_top backend_assertions u_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .state          (state),
    .backend_ctrl   (backend_ctrl),
    .dmem_req_valid (dmem_req_valid),
    .dmem_req       (dmem_req),
    .dmem_ready     (dmem_ready),
    .instr_retired  (instr_retired),
    .mem_fault      (mem_fault)
);

`default_nettype wire

//--- bench/backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module backend_tb import backend_pkg::*; ();

    // About 120 instructions at up to 12 cycles each, plus reset
    localparam int TIMEOUT_CYCLES = 2000;

    logic           clk;
    logic           rst_n;
    logic           frontend_valid;
    decoded_instr_t frontend_instr;
    backend_ctrl_t  backend_ctrl;
    logic           dmem_req_valid;
    dmem_req_t      dmem_req;
    logic           dmem_ready;
    logic           dmem_resp_valid;
    dmem_resp_t     dmem_resp;
    logic           instr_retired;
    logic           mem_fault;

    int          seed = 32'hee9f_7076;
    int          errors = 0;
    int          cycle_count = 0;
    logic [63:0] mem [0:255];
    logic [63:0] next_pc = 64'h8000_0000;
    logic [63:0] last_pc;
    dmem_req_t   held_req;
    dmem_req_t   last_req;
    logic [63:0] resp_data;
    bit          hold = 0;
    bit          pend = 0;
    bit          inject_error = 0;
    int          ready_wait;
    int          resp_wait;
    int          ready_max = 3;
    bit          r_retired;
    bit          r_fault;
    bit          r_redir;
    logic [63:0] r_redir_pc;
    int          r_cycles;

    backend_top uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, tests did not finish", cycle_count);
            $display("Finished with %0d check errors and %0d assertion failures",
                     errors + 1, uut.u_assertions.failures);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int rand_upto(input int max);
        return $unsigned($random(seed)) % (max + 1);
    endfunction

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond)
        else begin
            errors++;
            $display("Failure: %s", what);
        end
    endtask

    // Memory model with random ready and response delays
    always @(negedge clk) begin
        dmem_ready      = 1'b0;
        dmem_resp_valid = 1'b0;
        dmem_resp       = '0;
        if (pend) begin
            if (resp_wait == 0) begin
                dmem_resp_valid  = 1'b1;
                dmem_resp.data   = resp_data;
                dmem_resp.error  = inject_error;
                pend             = 0;
            end else begin
                resp_wait--;
            end
        end else if (dmem_req_valid) begin
            if (!hold) begin
                held_req   = dmem_req;
                hold       = 1;
                ready_wait = rand_upto(ready_max);
            end else begin
                check_true(dmem_req === held_req, "request changed while waiting for ready");
            end
            if (ready_wait == 0) begin
                dmem_ready = 1'b1;
                last_req   = dmem_req;
                resp_data  = mem[dmem_req.addr[10:3]];
                if (dmem_req.we && !inject_error) begin
                    for (int b = 0; b < 8; b++) begin
                        if (dmem_req.wstrb[b]) begin
                            mem[dmem_req.addr[10:3]][8*b +: 8] = dmem_req.wdata[8*b +: 8];
                        end
                    end
                end
                hold      = 0;
                pend      = 1;
                resp_wait = rand_upto(3);
            end else begin
                ready_wait--;
            end
        end
    end

    function automatic decoded_instr_t mk(input opcode_e op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [2:0] f3, input logic [6:0] f7,
                                          input logic [63:0] imm);
        decoded_instr_t i;
        i        = '0;
        i.opcode = op;
        i.rd     = rd;
        i.rs1    = rs1;
        i.rs2    = rs2;
        i.funct3 = f3;
        i.funct7 = f7;
        i.imm    = imm;
        return i;
    endfunction

    // Offers one instruction and waits for retire or fault
    task automatic run_instr(input decoded_instr_t ins);
        bit done;
        done     = 0;
        ins.pc   = next_pc;
        last_pc  = next_pc;
        next_pc += 4;
        @(negedge clk);
        frontend_valid = 1'b1;
        frontend_instr = ins;
        @(posedge clk);
        check_true(!backend_ctrl.stall, "back end stalled when an instruction was offered");
        @(negedge clk);
        frontend_valid = 1'b0;
        r_retired = 0;
        r_fault   = 0;
        r_redir   = 0;
        r_cycles  = 0;
        while (!done) begin
            @(posedge clk);
            r_cycles++;
            if (backend_ctrl.redirect) begin
                r_redir    = 1;
                r_redir_pc = backend_ctrl.redirect_pc;
                check_true(instr_retired, "redirect raised outside writeback");
            end
            if (instr_retired || mem_fault) begin
                r_retired = instr_retired;
                r_fault   = mem_fault;
                done      = 1;
            end
        end
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [63:0] val);
        run_instr(mk(OP_IMM, rd, 5'd0, 5'd0, 3'b000, 7'd0, val));
    endtask

    // A doubleword store exposes the register on dmem_req.wdata
    task automatic read_reg(input logic [4:0] rs, output logic [63:0] val);
        run_instr(mk(STORE, 5'd0, 5'd0, rs, 3'b011, 7'd0, 64'h100));
        check_val("dmem_req.wstrb", last_req.wstrb, 8'hff);
        check_val("dmem_req.addr", last_req.addr, 32'h100);
        val = last_req.wdata;
    endtask

    function automatic logic [63:0] ref_alu(input string op, input logic [63:0] a,
                                            input logic [63:0] b);
        case (op)
            "SUB": return a - b;
            "SLT": return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            "SLTU": return (a < b) ? 64'd1 : 64'd0;
            "XOR": return a ^ b;
            "OR": return a | b;
            "AND": return a & b;
            "SLL": return a << b[5:0];
            "SRL": return a >> b[5:0];
            default: return $signed(a) >>> b[5:0];
        endcase
    endfunction

    function automatic bit ref_branch(input logic [2:0] f3, input logic [63:0] a,
                                      input logic [63:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [63:0] ref_load(input logic [2:0] f3, input logic [63:0] v,
                                             input int off);
        logic [63:0] s;
        s = v >> (off * 8);
        case (f3)
            3'b000: return 64'($signed(s[7:0]));
            3'b001: return 64'($signed(s[15:0]));
            3'b010: return 64'($signed(s[31:0]));
            3'b100: return 64'(s[7:0]);
            3'b101: return 64'(s[15:0]);
            3'b110: return 64'(s[31:0]);
            default: return s;
        endcase
    endfunction

    task automatic test_reset_and_store();
        logic [63:0] v;
        @(posedge clk);
        check_true(!backend_ctrl.stall && !backend_ctrl.redirect, "control not idle after reset");
        check_true(!dmem_req_valid && !instr_retired, "outputs active after reset");
        set_reg(5'd2, 64'h1234);
        run_instr(mk(OP_IMM, 5'd1, 5'd2, 5'd0, 3'b000, 7'd0, 64'h55));
        read_reg(5'd1, v);
        check_val("dmem_req.wdata", v, 64'h1289);
    endtask

    task automatic alu_case(input string op, input logic [2:0] f3, input logic [6:0] f7);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] v;
        a = rand64();
        b = rand64();
        set_reg(5'd3, a);
        set_reg(5'd4, b);
        run_instr(mk(OP, 5'd5, 5'd3, 5'd4, f3, f7, 64'd0));
        read_reg(5'd5, v);
        check_val({"x5 after ", op}, v, ref_alu(op, a, b));
    endtask

    task automatic test_alu();
        logic [63:0] v;
        logic [63:0] imm;
        alu_case("SUB", 3'b000, 7'h20);
        alu_case("SLT", 3'b010, 7'h00);
        alu_case("SLTU", 3'b011, 7'h00);
        alu_case("XOR", 3'b100, 7'h00);
        alu_case("OR", 3'b110, 7'h00);
        alu_case("AND", 3'b111, 7'h00);
        alu_case("SLL", 3'b001, 7'h00);
        alu_case("SRL", 3'b101, 7'h00);
        alu_case("SRA", 3'b101, 7'h20);
        imm = 64'hffff_ffff_8765_4000;
        run_instr(mk(LUI, 5'd6, 5'd0, 5'd0, 3'b000, 7'd0, imm));
        read_reg(5'd6, v);
        check_val("x6 after LUI", v, imm);
        run_instr(mk(AUIPC, 5'd7, 5'd0, 5'd0, 3'b000, 7'd0, 64'h3000));
        v = last_pc + 64'h3000;
        read_reg(5'd7, imm);
        check_val("x7 after AUIPC", imm, v);
        run_instr(mk(OP_IMM, 5'd0, 5'd3, 5'd0, 3'b000, 7'd0, 64'd1));
        read_reg(5'd0, v);
        check_val("x0", v, 64'd0);
    endtask

    task automatic test_branches();
        logic [2:0]  f3s [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        logic [4:0]  ra [3] = '{5'd8, 5'd9, 5'd10};
        logic [4:0]  rb [3] = '{5'd8, 5'd10, 5'd9};
        logic [63:0] vals [11];
        logic [63:0] v;
        logic [63:0] link;
        bit          taken;
        vals[8]  = 64'd7;
        vals[9]  = '1;
        vals[10] = 64'd1;
        for (int r = 8; r <= 10; r++) begin
            set_reg(5'(r), vals[r]);
        end
        foreach (f3s[f]) begin
            for (int p = 0; p < 3; p++) begin
                taken = ref_branch(f3s[f], vals[ra[p]], vals[rb[p]]);
                run_instr(mk(BRANCH, 5'd0, ra[p], rb[p], f3s[f], 7'd0, 64'h40));
                check_val("backend_ctrl.redirect", r_redir, taken);
                if (taken) begin
                    check_val("backend_ctrl.redirect_pc", r_redir_pc, last_pc + 64'h40);
                end
            end
        end
        run_instr(mk(JAL, 5'd11, 5'd0, 5'd0, 3'b000, 7'd0, 64'hffff_ffff_ffff_ff00));
        check_val("backend_ctrl.redirect", r_redir, 1'b1);
        check_val("backend_ctrl.redirect_pc", r_redir_pc, last_pc - 64'h100);
        v = last_pc + 4;
        read_reg(5'd11, link);
        check_val("x11 after JAL", link, v);
        run_instr(mk(JALR, 5'd12, 5'd10, 5'd0, 3'b000, 7'd0, 64'h200));
        check_val("backend_ctrl.redirect", r_redir, 1'b1);
        check_val("backend_ctrl.redirect_pc", r_redir_pc, 64'h200);
        v = last_pc + 4;
        read_reg(5'd12, link);
        check_val("x12 after JALR", link, v);
    endtask

    task automatic store_case(input logic [2:0] f3, input int off, input logic [63:0] val);
        logic [7:0]  strb;
        logic [63:0] mask;
        strb = (f3 == 3'b000) ? 8'h01 : (f3 == 3'b001) ? 8'h03 : 8'h0f;
        strb = strb << off;
        for (int b = 0; b < 8; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        run_instr(mk(STORE, 5'd0, 5'd13, 5'd14, f3, 7'd0, 64'(off)));
        check_val("dmem_req.wstrb", last_req.wstrb, strb);
        check_val("dmem_req.addr", last_req.addr, 32'h200);
        check_val("dmem_req.wdata", last_req.wdata & mask, (val << (8 * off)) & mask);
    endtask

    task automatic test_load_store();
        logic [63:0] val;
        logic [63:0] got;
        logic [2:0]  lf3 [7] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101, 3'b110, 3'b011};
        int          loff [7] = '{3, 6, 4, 5, 2, 0, 0};
        val = rand64();
        set_reg(5'd13, 64'h200);
        set_reg(5'd14, val);
        for (int o = 0; o < 8; o++) begin
            store_case(3'b000, o, val);
        end
        for (int o = 0; o < 8; o += 2) begin
            store_case(3'b001, o, val);
        end
        store_case(3'b010, 0, val);
        store_case(3'b010, 4, val);
        val = rand64() | 64'h8000_8000_8000_8000;
        set_reg(5'd13, 64'h300);
        set_reg(5'd14, val);
        run_instr(mk(STORE, 5'd0, 5'd13, 5'd14, 3'b011, 7'd0, 64'd0));
        foreach (lf3[k]) begin
            run_instr(mk(LOAD, 5'd15, 5'd13, 5'd0, lf3[k], 7'd0, 64'(loff[k])));
            read_reg(5'd15, got);
            check_val("x15 after load", got, ref_load(lf3[k], val, loff[k]));
        end
    endtask

    task automatic test_timing();
        run_instr(mk(OP_IMM, 5'd16, 5'd0, 5'd0, 3'b000, 7'd0, 64'h77));
        check_val("instr_retired cycle", 64'(r_cycles), 64'd3);
        ready_max = 6;
        for (int k = 0; k < 4; k++) begin
            run_instr(mk(STORE, 5'd0, 5'd0, 5'd16, 3'b011, 7'd0, 64'h180));
            check_val("dmem_req.wdata", last_req.wdata, 64'h77);
        end
        ready_max = 3;
    endtask

    task automatic test_fault();
        logic [63:0] v;
        set_reg(5'd17, 64'h55);
        inject_error = 1;
        run_instr(mk(LOAD, 5'd17, 5'd0, 5'd0, 3'b011, 7'd0, 64'h300));
        check_true(r_fault && !r_retired, "error response did not raise mem_fault");
        @(negedge clk);
        inject_error = 0;
        read_reg(5'd17, v);
        check_val("x17 after faulted load", v, 64'h55);
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        frontend_valid  = 1'b0;
        frontend_instr  = '0;
        dmem_ready      = 1'b0;
        dmem_resp_valid = 1'b0;
        dmem_resp       = '0;
        // Every word depends on its full byte address
        for (int i = 0; i < 256; i++) begin
            mem[i] = {32'(i * 8) ^ 32'h5a5a_5a5a, ~32'(i * 8)};
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_and_store();
        test_alu();
        test_branches();
        test_load_store();
        test_timing();
        test_fault();
        $display("Finished with %0d check errors and %0d assertion failures",
                 errors, uut.u_assertions.failures);
        if (errors == 0 && uut.u_assertions.failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
source/backend_pkg.sv
source/backend_fsm.sv
source/register_file.sv
source/execute_unit.sv
source/load_store_unit.sv
source/backend_top.sv
bench/backend_assertions.sv
bench/backend_tb.sv

//--- Bender.yml
package:
  name: backend

export_include_dirs:
  - include

sources:
  - files:
      - source/backend_pkg.sv
      - source/backend_fsm.sv
      - source/register_file.sv
      - source/execute_unit.sv
      - source/load_store_unit.sv
      - source/backend_top.sv
  - target: test
    files:
      - bench/backend_assertions.sv
      - bench/backend_tb.sv
